/* Makefile */
# Verilator flow for the RV32IM decoder
TOP       ?= tb_rv_decoder
DUT_TOP   ?= rv_decoder
VERILATOR ?= verilator
FILELIST  ?= build.f
FLAGS     ?= --assert --timescale 1ns/100ps
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "sim passed" || \
		(echo "sim failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+common
+incdir+tests
common/rv_decode_pkg.sv
decode/imm_gen.sv
decode/alu_op_decode.sv
decode/exec_ctrl_decode.sv
source/rv_decoder.sv
tests/tb_rv_decoder.sv

/* common/rv_decode_pkg.sv */
`include "rv_decode_settings.svh"

package rv_decode_pkg;

   // order of the m-group follows funct3, MUL is 000
   typedef enum logic [`RV_ALU_OP_W-1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_MUL,
      ALU_MULH,
      ALU_MULHSU,
      ALU_MULHU,
      ALU_DIV,
      ALU_DIVU,
      ALU_REM,
      ALU_REMU
   } alu_op_e;

   typedef enum logic [2:0] {
      STAGE_FETCH,   // retire, writeback happens here
      STAGE_LOAD,
      STAGE_STORE,
      STAGE_BRANCH,
      STAGE_SYSTEM,
      STAGE_TRAP     // illegal or unsupported word
   } next_stage_e;

   typedef enum logic {S1_REGVAL1, S1_PC} s1_sel_e;                    // alu operand a
   typedef enum logic [1:0] {S2_REGVAL2, S2_IMM} s2_sel_e;             // alu operand b
   typedef enum logic [1:0] {REG_IN_ALU, REG_IN_IMM} reg_input_e;      // rd write source

   typedef logic [5:0] branch_mask_t;  // eq, ne, lt, ge, ltu, geu from bit 0

   typedef struct packed {
      s1_sel_e     s1_sel;
      s2_sel_e     s2_sel;
      next_stage_e next_stage;
      logic        writeback_from_alu;  // rd <= alu result in fetch
      logic        writeback_from_imm;  // rd <= imm, lui only
      logic        next_pc_from_alu;    // jumps
      reg_input_e  reg_input_sel;
      logic        write_reg;           // link write of jal/jalr
   } exec_ctrl_t;

   typedef struct packed {
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [`RV_XLEN-1:0]       imm;
      alu_op_e                   alu_op;
      branch_mask_t              branch_mask;
      logic [`RV_F3_W-1:0]       funct3;
      exec_ctrl_t                ctrl;
   } decoded_t;

endpackage

/* common/rv_decode_settings.svh */
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

`define RV_XLEN         32          // data and immediate width
`define RV_REG_ADDR_W   5           // x0..x31
`define RV_ALU_OP_W     5           // alu operation code
`define RV_OPCODE_W     5           // major opcode, instr[6:2]
`define RV_F3_W         3
`define RV_F7_W         7
`define RV_QUAD_32      2'b11       // instr[1:0] of a full-size word

`define RV_OP_LOAD      5'b00000
`define RV_OP_MISC_MEM  5'b00011    // fence
`define RV_OP_OP_IMM    5'b00100
`define RV_OP_AUIPC     5'b00101
`define RV_OP_STORE     5'b01000
`define RV_OP_OP        5'b01100
`define RV_OP_LUI       5'b01101
`define RV_OP_BRANCH    5'b11000
`define RV_OP_JALR      5'b11001
`define RV_OP_JAL       5'b11011
`define RV_OP_SYSTEM    5'b11100    // ecall, ebreak, csr

`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

`define RV_F3_ADD       3'b000      // also sub, mul
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL       3'b101      // also sra
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

`define RV_F7_ALT       7'b0100000  // sub, sra
`define RV_F7_MULDIV    7'b0000001  // m extension

`endif

/* decode/alu_op_decode.sv */
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module alu_op_decode (
   input  logic [`RV_XLEN-1:0]     i_instr,  // raw instruction word
   output rv_decode_pkg::alu_op_e  o_alu_op  // operation for exec stage
);

   logic [`RV_OPCODE_W-1:0] opcode;
   logic [`RV_F3_W-1:0]     funct3;
   logic [`RV_F7_W-1:0]     funct7;
   logic                    is_32;    // full-size encoding
   rv_decode_pkg::alu_op_e  base_op;  // plain integer op of funct3
   rv_decode_pkg::alu_op_e  mul_op;   // m-extension op of funct3

   assign opcode = i_instr[6:2];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];
   assign is_32  = (i_instr[1:0] == `RV_QUAD_32);

   always_comb begin
      case (funct3)
         `RV_F3_ADD:  begin base_op = rv_decode_pkg::ALU_ADD;  mul_op = rv_decode_pkg::ALU_MUL;    end
         `RV_F3_SLL:  begin base_op = rv_decode_pkg::ALU_SLL;  mul_op = rv_decode_pkg::ALU_MULH;   end
         `RV_F3_SLT:  begin base_op = rv_decode_pkg::ALU_SLT;  mul_op = rv_decode_pkg::ALU_MULHSU; end
         `RV_F3_SLTU: begin base_op = rv_decode_pkg::ALU_SLTU; mul_op = rv_decode_pkg::ALU_MULHU;  end
         `RV_F3_XOR:  begin base_op = rv_decode_pkg::ALU_XOR;  mul_op = rv_decode_pkg::ALU_DIV;    end
         `RV_F3_SRL:  begin base_op = rv_decode_pkg::ALU_SRL;  mul_op = rv_decode_pkg::ALU_DIVU;   end
         `RV_F3_OR:   begin base_op = rv_decode_pkg::ALU_OR;   mul_op = rv_decode_pkg::ALU_REM;    end
         default:     begin base_op = rv_decode_pkg::ALU_AND;  mul_op = rv_decode_pkg::ALU_REMU;   end
      endcase
   end

   always_comb begin
      o_alu_op = rv_decode_pkg::ALU_ADD;  // address calc and don't-care cases
      if (is_32 && opcode == `RV_OP_OP) begin
         if (funct7 == `RV_F7_MULDIV) begin
            o_alu_op = mul_op;
         end else if (funct7 == `RV_F7_ALT && funct3 == `RV_F3_ADD) begin
            o_alu_op = rv_decode_pkg::ALU_SUB;
         end else if (funct7 == `RV_F7_ALT && funct3 == `RV_F3_SRL) begin
            o_alu_op = rv_decode_pkg::ALU_SRA;
         end else begin
            o_alu_op = base_op;
         end
      end else if (is_32 && opcode == `RV_OP_OP_IMM) begin
         // no subi, only the shift uses funct7
         if (funct3 == `RV_F3_SRL && funct7[5]) begin
            o_alu_op = rv_decode_pkg::ALU_SRA;  // srai
         end else begin
            o_alu_op = base_op;
         end
      end
   end

endmodule

/* decode/exec_ctrl_decode.sv */
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module exec_ctrl_decode (
   input  logic [`RV_XLEN-1:0]          i_instr,        // raw instruction word
   output rv_decode_pkg::exec_ctrl_t    o_ctrl,         // exec muxes and flags
   output rv_decode_pkg::branch_mask_t  o_branch_mask   // one-hot compare select
);

   logic [`RV_OPCODE_W-1:0] opcode;
   logic [`RV_F3_W-1:0]     funct3;
   logic                    is_32;      // low bits 11
   logic                    is_branch;

   assign opcode    = i_instr[6:2];
   assign funct3    = i_instr[14:12];
   assign is_32     = (i_instr[1:0] == `RV_QUAD_32);
   assign is_branch = is_32 && (opcode == `RV_OP_BRANCH);

   always_comb begin
      o_ctrl.s1_sel             = rv_decode_pkg::S1_REGVAL1;
      o_ctrl.s2_sel             = rv_decode_pkg::S2_REGVAL2;
      o_ctrl.next_stage         = rv_decode_pkg::STAGE_TRAP;  // unless matched below
      o_ctrl.writeback_from_alu = 1'b0;
      o_ctrl.writeback_from_imm = 1'b0;
      o_ctrl.next_pc_from_alu   = 1'b0;
      o_ctrl.reg_input_sel      = rv_decode_pkg::REG_IN_ALU;
      o_ctrl.write_reg          = 1'b0;
      if (is_32) begin
         case (opcode)
            `RV_OP_OP: begin
               o_ctrl.writeback_from_alu = 1'b1;  // rd written in fetch
               o_ctrl.next_stage         = rv_decode_pkg::STAGE_FETCH;
            end
            `RV_OP_OP_IMM: begin
               o_ctrl.s2_sel             = rv_decode_pkg::S2_IMM;
               o_ctrl.writeback_from_alu = 1'b1;
               o_ctrl.next_stage         = rv_decode_pkg::STAGE_FETCH;
            end
            `RV_OP_LOAD: begin  // alu forms rs1 + imm address
               o_ctrl.s2_sel     = rv_decode_pkg::S2_IMM;
               o_ctrl.next_stage = rv_decode_pkg::STAGE_LOAD;
            end
            `RV_OP_STORE: begin
               o_ctrl.s2_sel     = rv_decode_pkg::S2_IMM;
               o_ctrl.next_stage = rv_decode_pkg::STAGE_STORE;
            end
            `RV_OP_JAL,
            `RV_OP_JALR: begin
               // target from alu, link value written to rd
               o_ctrl.s1_sel           = (opcode == `RV_OP_JAL) ? rv_decode_pkg::S1_PC
                                                                : rv_decode_pkg::S1_REGVAL1;
               o_ctrl.s2_sel           = rv_decode_pkg::S2_IMM;
               o_ctrl.write_reg        = 1'b1;
               o_ctrl.reg_input_sel    = rv_decode_pkg::REG_IN_ALU;
               o_ctrl.next_pc_from_alu = 1'b1;
               o_ctrl.next_stage       = rv_decode_pkg::STAGE_FETCH;
            end
            `RV_OP_BRANCH: begin  // alu compares rs1 and rs2
               o_ctrl.next_stage = rv_decode_pkg::STAGE_BRANCH;
            end
            `RV_OP_AUIPC: begin  // pc + upper imm
               o_ctrl.s1_sel             = rv_decode_pkg::S1_PC;
               o_ctrl.s2_sel             = rv_decode_pkg::S2_IMM;
               o_ctrl.writeback_from_alu = 1'b1;
               o_ctrl.next_stage         = rv_decode_pkg::STAGE_FETCH;
            end
            `RV_OP_LUI: begin  // imm straight into rd, alu idle
               o_ctrl.writeback_from_imm = 1'b1;
               o_ctrl.reg_input_sel      = rv_decode_pkg::REG_IN_IMM;
               o_ctrl.next_stage         = rv_decode_pkg::STAGE_FETCH;
            end
            `RV_OP_MISC_MEM: o_ctrl.next_stage = rv_decode_pkg::STAGE_FETCH;  // fence is a nop
            `RV_OP_SYSTEM:   o_ctrl.next_stage = rv_decode_pkg::STAGE_SYSTEM;
            default:         o_ctrl.next_stage = rv_decode_pkg::STAGE_TRAP;
         endcase
      end
   end

   always_comb begin
      o_branch_mask = '0;
      if (is_branch) begin
         case (funct3)
            `RV_F3_BEQ:  o_branch_mask[0] = 1'b1;
            `RV_F3_BNE:  o_branch_mask[1] = 1'b1;
            `RV_F3_BLT:  o_branch_mask[2] = 1'b1;
            `RV_F3_BGE:  o_branch_mask[3] = 1'b1;
            `RV_F3_BLTU: o_branch_mask[4] = 1'b1;
            `RV_F3_BGEU: o_branch_mask[5] = 1'b1;
            default:     o_branch_mask    = '0;  // 010 and 011 are reserved
         endcase
      end
   end

   // rd has a single write source in fetch
   always_comb begin
      assert (!(o_ctrl.writeback_from_alu && o_ctrl.writeback_from_imm))
         else $error("exec_ctrl_decode: both writeback sources set for %h", i_instr);
   end

endmodule

/* decode/imm_gen.sv */
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module imm_gen (
   input  logic [`RV_XLEN-1:0] i_instr,  // raw instruction word
   output logic [`RV_XLEN-1:0] o_imm     // immediate, already extended
);

   logic [`RV_OPCODE_W-1:0] opcode;  // instr[6:2]
   logic                    sign;    // every format takes its sign from bit 31

   assign opcode = i_instr[6:2];
   assign sign   = i_instr[31];

   always_comb begin
      case (opcode)
         `RV_OP_STORE: begin  // s-type, low part sits in the rd field
            o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
         end
         `RV_OP_BRANCH: begin  // b-type, halfword offset
            o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};
         end
         `RV_OP_LUI,
         `RV_OP_AUIPC: begin  // u-type, upper 20 bits
            o_imm = {i_instr[31:12], 12'b0};
         end
         `RV_OP_JAL: begin  // j-type, scrambled offset
            o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
         end
         default: begin
            // i-type, also loads, jalr, system
            // r-type lands here too, value unused there
            o_imm = {{20{sign}}, i_instr[31:20]};
         end
      endcase
   end

endmodule

/* source/rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module rv_decoder (
   input  logic                    i_clk,
   input  logic                    i_arst_n,  // async, active low
   input  logic                    i_en,      // instruction present this cycle
   input  logic [`RV_XLEN-1:0]     i_instr,
   output logic                    o_valid,   // bundle captured last cycle
   output rv_decode_pkg::decoded_t o_dec      // registered bundle
);

   logic [`RV_XLEN-1:0]          imm;
   rv_decode_pkg::alu_op_e       alu_op;
   rv_decode_pkg::exec_ctrl_t    ctrl;
   rv_decode_pkg::branch_mask_t  branch_mask;
   rv_decode_pkg::decoded_t      dec_next;     // combinational bundle

   imm_gen u_imm_gen (
      .i_instr (i_instr),
      .o_imm   (imm)
   );

   alu_op_decode u_alu_op_decode (
      .i_instr  (i_instr),
      .o_alu_op (alu_op)
   );

   exec_ctrl_decode u_exec_ctrl_decode (
      .i_instr       (i_instr),
      .o_ctrl        (ctrl),
      .o_branch_mask (branch_mask)
   );

   always_comb begin
      dec_next.rs1         = i_instr[19:15];  // fixed fields, no format check
      dec_next.rs2         = i_instr[24:20];
      dec_next.rd          = i_instr[11:7];
      dec_next.imm         = imm;
      dec_next.alu_op      = alu_op;
      dec_next.branch_mask = branch_mask;
      dec_next.funct3      = i_instr[14:12];  // load/store width for mem stage
      dec_next.ctrl        = ctrl;
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_valid <= 1'b0;
         o_dec   <= '0;  // all flags inactive
      end else begin
         o_valid <= i_en;
         if (i_en) begin
            o_dec <= dec_next;  // holds through idle cycles
         end
      end
   end

   // branch unit expects a single compare
   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_valid |-> $onehot0(o_dec.branch_mask))
      else $error("rv_decoder: branch mask not one-hot %b", o_dec.branch_mask);

   assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $rose(o_valid) |-> $past(i_en))
      else $error("rv_decoder: o_valid rose without i_en");  // enable-only handshake

endmodule

/* tests/tb_vectors.svh */
// columns: test name, instruction word, expected immediate, alu op, branch mask, control class
// rs1, rs2, rd and funct3 are checked against the word's fixed fields in check_row
task automatic load_table();
   rv_decode_pkg::exec_ctrl_t c_op, c_opi, c_load, c_store, c_jal, c_jalr;
   rv_decode_pkg::exec_ctrl_t c_br, c_auipc, c_lui, c_fence, c_sys, c_trap;
   // make_ctrl(s1 pc, s2 imm, stage, {wb_alu, wb_imm, next_pc_alu, write_reg}, rd from imm)
   c_op    = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_FETCH,  4'b1000, 1'b0);
   c_opi   = make_ctrl(1'b0, 1'b1, rv_decode_pkg::STAGE_FETCH,  4'b1000, 1'b0);
   c_load  = make_ctrl(1'b0, 1'b1, rv_decode_pkg::STAGE_LOAD,   4'b0000, 1'b0);
   c_store = make_ctrl(1'b0, 1'b1, rv_decode_pkg::STAGE_STORE,  4'b0000, 1'b0);
   c_jal   = make_ctrl(1'b1, 1'b1, rv_decode_pkg::STAGE_FETCH,  4'b0011, 1'b0);
   c_jalr  = make_ctrl(1'b0, 1'b1, rv_decode_pkg::STAGE_FETCH,  4'b0011, 1'b0);
   c_br    = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_BRANCH, 4'b0000, 1'b0);
   c_auipc = make_ctrl(1'b1, 1'b1, rv_decode_pkg::STAGE_FETCH,  4'b1000, 1'b0);
   c_lui   = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_FETCH,  4'b0100, 1'b1);
   c_fence = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_FETCH,  4'b0000, 1'b0);
   c_sys   = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_SYSTEM, 4'b0000, 1'b0);
   c_trap  = make_ctrl(1'b0, 1'b0, rv_decode_pkg::STAGE_TRAP,   4'b0000, 1'b0);
   // r-type rows use x3 = x1 op x2, imm is the i layout of bits 31:20
   add_row("add",      32'h002081B3, 32'h00000002, rv_decode_pkg::ALU_ADD,    6'b000000, c_op);
   add_row("sub",      32'h402081B3, 32'h00000402, rv_decode_pkg::ALU_SUB,    6'b000000, c_op);
   add_row("sra",      32'h4020D1B3, 32'h00000402, rv_decode_pkg::ALU_SRA,    6'b000000, c_op);
   add_row("mul",      32'h022081B3, 32'h00000022, rv_decode_pkg::ALU_MUL,    6'b000000, c_op);
   add_row("mulh",     32'h022091B3, 32'h00000022, rv_decode_pkg::ALU_MULH,   6'b000000, c_op);
   add_row("mulhsu",   32'h0220A1B3, 32'h00000022, rv_decode_pkg::ALU_MULHSU, 6'b000000, c_op);
   add_row("mulhu",    32'h0220B1B3, 32'h00000022, rv_decode_pkg::ALU_MULHU,  6'b000000, c_op);
   add_row("div",      32'h0220C1B3, 32'h00000022, rv_decode_pkg::ALU_DIV,    6'b000000, c_op);
   add_row("divu",     32'h0220D1B3, 32'h00000022, rv_decode_pkg::ALU_DIVU,   6'b000000, c_op);
   add_row("rem",      32'h0220E1B3, 32'h00000022, rv_decode_pkg::ALU_REM,    6'b000000, c_op);
   add_row("remu",     32'h0220F1B3, 32'h00000022, rv_decode_pkg::ALU_REMU,   6'b000000, c_op);
   add_row("srai",     32'h4040D193, 32'h00000404, rv_decode_pkg::ALU_SRA,    6'b000000, c_opi);
   add_row("addi_neg", 32'hFFF08193, 32'hFFFFFFFF, rv_decode_pkg::ALU_ADD,    6'b000000, c_opi);
   add_row("lw_neg",   32'hFF80A183, 32'hFFFFFFF8, rv_decode_pkg::ALU_ADD,    6'b000000, c_load);
   add_row("sw_pos",   32'h0020AA23, 32'h00000014, rv_decode_pkg::ALU_ADD,    6'b000000, c_store);
   add_row("beq",      32'h00208863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b000001, c_br);
   add_row("bne_neg",  32'hFE209EE3, 32'hFFFFFFFC, rv_decode_pkg::ALU_ADD,    6'b000010, c_br);
   add_row("blt",      32'h0020C863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b000100, c_br);
   add_row("bge",      32'h0020D863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b001000, c_br);
   add_row("bltu",     32'h0020E863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b010000, c_br);
   add_row("bgeu",     32'h0020F863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b100000, c_br);
   add_row("br_f3_2",  32'h0020A863, 32'h00000010, rv_decode_pkg::ALU_ADD,    6'b000000, c_br);
   add_row("lui_neg",  32'h800011B7, 32'h80001000, rv_decode_pkg::ALU_ADD,    6'b000000, c_lui);
   add_row("auipc",    32'h12345197, 32'h12345000, rv_decode_pkg::ALU_ADD,    6'b000000, c_auipc);
   add_row("jal_neg",  32'hFF9FF0EF, 32'hFFFFFFF8, rv_decode_pkg::ALU_ADD,    6'b000000, c_jal);
   add_row("jalr_pos", 32'h00C280E7, 32'h0000000C, rv_decode_pkg::ALU_ADD,    6'b000000, c_jalr);
   add_row("fence",    32'h0FF0000F, 32'h000000FF, rv_decode_pkg::ALU_ADD,    6'b000000, c_fence);
   add_row("ebreak",   32'h00100073, 32'h00000001, rv_decode_pkg::ALU_ADD,    6'b000000, c_sys);
   add_row("bad_op",   32'h002081FF, 32'h00000002, rv_decode_pkg::ALU_ADD,    6'b000000, c_trap);
   add_row("low_01",   32'h002081B1, 32'h00000002, rv_decode_pkg::ALU_ADD,    6'b000000, c_trap);
endtask

/* tests/tb_rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module tb_rv_decoder;

   localparam int WAIT_LIMIT = 8;  // cycles before a wait gives up

   logic                    i_clk;
   logic                    i_arst_n;
   logic                    i_en;
   logic [`RV_XLEN-1:0]     i_instr;
   logic                    o_valid;
   rv_decode_pkg::decoded_t o_dec;

   string                       name_q[$];   // table columns
   logic [`RV_XLEN-1:0]         instr_q[$];
   logic [`RV_XLEN-1:0]         imm_q[$];
   rv_decode_pkg::alu_op_e      alu_q[$];
   rv_decode_pkg::branch_mask_t mask_q[$];
   rv_decode_pkg::exec_ctrl_t   ctrl_q[$];

   int                      value_errs;  // wrong field values
   int                      proto_errs;  // handshake, latency, timeout
   logic [16:0]             lfsr;        // idle gap source
   rv_decode_pkg::decoded_t last;        // bundle that must hold when idle
   int                      gap;
   int                      waited;
   int                      row;

   rv_decoder i_dut (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (i_en),
      .i_instr  (i_instr),
      .o_valid  (o_valid),
      .o_dec    (o_dec)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;  // 10 ns period
   end

   function automatic rv_decode_pkg::exec_ctrl_t make_ctrl(
      input logic s1_pc, input logic s2_imm, input rv_decode_pkg::next_stage_e stage,
      input logic [3:0] flags, input logic rin_imm);
      rv_decode_pkg::exec_ctrl_t c;
      c.s1_sel             = s1_pc ? rv_decode_pkg::S1_PC : rv_decode_pkg::S1_REGVAL1;
      c.s2_sel             = s2_imm ? rv_decode_pkg::S2_IMM : rv_decode_pkg::S2_REGVAL2;
      c.next_stage         = stage;
      c.writeback_from_alu = flags[3];
      c.writeback_from_imm = flags[2];
      c.next_pc_from_alu   = flags[1];
      c.write_reg          = flags[0];
      c.reg_input_sel      = rin_imm ? rv_decode_pkg::REG_IN_IMM : rv_decode_pkg::REG_IN_ALU;
      return c;
   endfunction

   task automatic add_row(input string name, input logic [`RV_XLEN-1:0] word,
                          input logic [`RV_XLEN-1:0] imm, input rv_decode_pkg::alu_op_e op,
                          input rv_decode_pkg::branch_mask_t mask,
                          input rv_decode_pkg::exec_ctrl_t ctrl);
      name_q.push_back(name);
      instr_q.push_back(word);
      imm_q.push_back(imm);
      alu_q.push_back(op);
      mask_q.push_back(mask);
      ctrl_q.push_back(ctrl);
   endtask

   `include "tb_vectors.svh"

   function automatic logic [16:0] lfsr_step(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
   endfunction

   task automatic pick_gap(output int n);
      logic [1:0] bits;
      lfsr    = lfsr_step(lfsr);
      bits[0] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      bits[1] = lfsr[0];
      n       = int'(bits);  // 0..3 idle cycles
   endtask

   task automatic check_field(input string test, input string field,
                              input logic [79:0] exp, input logic [79:0] act);
      assert (exp == act) else begin
         $display("ERROR %s %s: expected %0h actual %0h", test, field, exp, act);
         value_errs++;
      end
   endtask

   function automatic rv_decode_pkg::decoded_t expected_dec(input int r);
      rv_decode_pkg::decoded_t e;
      logic [`RV_XLEN-1:0]     w;
      w             = instr_q[r];
      e.rs1         = w[19:15];  // fixed field spots
      e.rs2         = w[24:20];
      e.rd          = w[11:7];
      e.funct3      = w[14:12];
      e.imm         = imm_q[r];
      e.alu_op      = alu_q[r];
      e.branch_mask = mask_q[r];
      e.ctrl        = ctrl_q[r];
      return e;
   endfunction

   task automatic check_row(input int r);
      rv_decode_pkg::decoded_t d;
      rv_decode_pkg::decoded_t e;
      d = o_dec;
      e = expected_dec(r);
      check_field(name_q[r], "rs1",    80'(e.rs1), 80'(d.rs1));
      check_field(name_q[r], "rs2",    80'(e.rs2), 80'(d.rs2));
      check_field(name_q[r], "rd",     80'(e.rd), 80'(d.rd));
      check_field(name_q[r], "funct3", 80'(e.funct3), 80'(d.funct3));
      check_field(name_q[r], "imm",    80'(e.imm), 80'(d.imm));
      check_field(name_q[r], "alu_op", 80'(e.alu_op), 80'(d.alu_op));
      check_field(name_q[r], "mask",   80'(e.branch_mask), 80'(d.branch_mask));
      check_field(name_q[r], "ctrl",   80'(e.ctrl), 80'(d.ctrl));
   endtask

   task automatic wait_valid(output int n);
      n = 0;
      @(negedge i_clk);
      while (!o_valid && n < WAIT_LIMIT) begin  // bounded poll
         @(negedge i_clk);
         n++;
      end
   endtask

   initial begin
      value_errs = 0;
      proto_errs = 0;
      lfsr       = 17'd85945;
      last       = '0;
      i_arst_n   = 1'b0;
      i_en       = 1'b0;
      i_instr    = '0;
      load_table();
      repeat (16) begin  // outputs cleared while in reset
         @(negedge i_clk);
         check_field("reset", "o_valid", 80'(1'b0), 80'(o_valid));
         check_field("reset", "o_dec", 80'(0), 80'(o_dec));
      end
      @(posedge i_clk);
      i_arst_n <= 1'b1;
      @(negedge i_clk);
      check_field("after_reset", "o_valid", 80'(1'b0), 80'(o_valid));
      check_field("after_reset", "o_dec", 80'(0), 80'(o_dec));
      for (row = 0; row < name_q.size(); row++) begin
         pick_gap(gap);
         repeat (gap) begin
            @(posedge i_clk);
            i_en    <= 1'b0;
            i_instr <= '1;  // must not be captured
            @(negedge i_clk);
            check_field("idle", "o_valid", 80'(1'b0), 80'(o_valid));
            check_field("idle", "o_dec hold", 80'(last), 80'(o_dec));
         end
         @(posedge i_clk);
         i_en    <= 1'b1;
         i_instr <= instr_q[row];
         @(negedge i_clk);
         check_field(name_q[row], "o_valid early", 80'(1'b0), 80'(o_valid));
         @(posedge i_clk);  // capture edge
         i_en <= 1'b0;
         wait_valid(waited);
         assert (o_valid) else begin
            $display("%s: o_valid never rose within %0d cycles", name_q[row], WAIT_LIMIT);
            proto_errs++;
         end
         if (o_valid) begin
            assert (waited == 0) else begin
               $display("%s: o_valid came %0d cycles late", name_q[row], waited);
               proto_errs++;
            end
            check_row(row);
         end
         last = expected_dec(row);
      end
      @(posedge i_clk);
      i_instr <= '1;  // must not be captured
      repeat (2) begin  // trailing idle after the last row
         @(negedge i_clk);
         check_field("final_idle", "o_valid", 80'(1'b0), 80'(o_valid));
         check_field("final_idle", "o_dec hold", 80'(last), 80'(o_dec));
      end
      $display("errors: %0d value, %0d handshake", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
